/* Makefile */
TOP := tb_dbg_uart_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f dbg_uart_top.f --top-module $(TOP)

# The pipeline status is the grep status, so a missing pass line fails the target.
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Everything OK" > /dev/null

lint:
	verilator --lint-only --timing -Wall -f dbg_uart_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dbg_uart_top.f */
hw/dbg_pkg.sv
hw/dbg_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_decoder.sv
hw/mem_exec.sv
hw/resp_sender.sv
hw/dbg_uart_top.sv
dv/tb_dbg_uart_top.sv

/* dv/tb_dbg_uart_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dbg_uart_top;

    localparam int CLKS_PER_BIT = 8;
    localparam int DEPTH        = 16;
    localparam int N_TESTS      = 25;
    localparam int RESP_WAIT    = 12 * 10 * CLKS_PER_BIT;     // One long exchange.
    localparam int CYCLE_LIMIT  = N_TESTS * 12 * 10 * CLKS_PER_BIT * 2;

    logic i_clock;
    logic i_arst_n;
    logic i_rx;
    logic o_tx;

    // Host side model state.
    dbg_pkg::word_t prog_m  [DEPTH];
    dbg_pkg::word_t data_m  [DEPTH];
    logic           dirty_m [DEPTH];

    dbg_pkg::word_t exp_word [$];
    int             exp_nb   [$];
    logic [7:0]     rx_bytes [$];   // Bytes decoded from o_tx.

    int cycles    = 0;
    int errors    = 0;
    int checks    = 0;
    int tests     = 0;
    int base_errs = 0;

    dbg_uart_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PROG_DEPTH  (DEPTH),
        .DATA_DEPTH  (DEPTH),
        .RESP_CREDITS(2)
    ) dbg_uart_top_inst (
        .i_clock (i_clock),
        .i_arst_n(i_arst_n),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;
    end

    //////////////////////////////
    // Reference model.
    //////////////////////////////
    function automatic dbg_pkg::word_t ref_response(input logic [7:0] op,
            input dbg_pkg::addr_t addr, input dbg_pkg::word_t data, output int nb);
        int a;
        a  = int'(addr) % DEPTH;
        nb = 1;
        ref_response = {24'd0, dbg_pkg::RESP_ACK};
        case (op)
            dbg_pkg::OP_WR_PROG: prog_m[a] = data;
            dbg_pkg::OP_RD_PROG: begin
                nb = 4;
                ref_response = prog_m[a];
            end
            dbg_pkg::OP_WR_DATA: begin
                data_m[a]  = data;
                dirty_m[a] = 1'b1;
            end
            dbg_pkg::OP_RD_DATA: begin
                nb = 4;
                ref_response = dirty_m[a] ? data_m[a] : '0;   // Clean word reads zero.
            end
            dbg_pkg::OP_RD_DIRTY: ref_response = {31'd0, dirty_m[a]};
            dbg_pkg::OP_SOFT_RESET: begin
                for (int i = 0; i < DEPTH; i++) dirty_m[i] = 1'b0;
            end
            default: ref_response = {24'd0, dbg_pkg::RESP_ERR};
        endcase
    endfunction

    task automatic check_word(input dbg_pkg::word_t got, input dbg_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error: o_tx word got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: o_tx byte got %h expected %h", got, exp);
            errors++;
        end
    endtask

    //////////////////////////////
    // Serial host side.
    //////////////////////////////
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};   // Stop, data LSB first, start.
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clock);
            i_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge i_clock);
        end
    endtask

    task automatic send_cmd(input logic [7:0] op, input dbg_pkg::addr_t addr,
            input dbg_pkg::word_t data);
        int             nb;
        dbg_pkg::word_t w;
        w = ref_response(op, addr, data, nb);
        exp_word.push_back(w);
        exp_nb.push_back(nb);
        send_byte(op);
        if (op >= 8'h01 && op <= 8'h05) send_byte(addr);
        if (op == dbg_pkg::OP_WR_PROG || op == dbg_pkg::OP_WR_DATA) begin
            for (int i = 3; i >= 0; i--) send_byte(data[8*i +: 8]);   // MSB first.
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (exp_nb.size() != 0 && waited < RESP_WAIT) begin
            @(posedge i_clock);
            waited++;
        end
        if (exp_nb.size() != 0) begin
            $display("%s: response did not arrive within %0d cycles", name, RESP_WAIT);
            errors++;
            exp_nb.delete();
            exp_word.delete();
            rx_bytes.delete();
        end
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == base_errs) ? "ok" : "FAILED");
        base_errs = errors;
    endtask

    task automatic run_test(input string name, input logic [7:0] op,
            input dbg_pkg::addr_t addr, input dbg_pkg::word_t data);
        send_cmd(op, addr, data);
        finish_test(name);
    endtask

    // Frame decoder on o_tx, sampled at bit centers on falling edges.
    initial begin : collect_tx
        logic [7:0] b;
        forever begin
            @(negedge i_clock);
            if (o_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge i_clock);
                if (o_tx !== 1'b0) begin
                    $display("o_tx start bit did not hold low");
                    errors++;
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (CLKS_PER_BIT) @(negedge i_clock);
                        b[i] = o_tx;
                    end
                    repeat (CLKS_PER_BIT) @(negedge i_clock);
                    if (o_tx !== 1'b1) begin
                        $display("o_tx stop bit was low");
                        errors++;
                    end
                    rx_bytes.push_back(b);
                end
            end
        end
    end

    // Pops one whole response once all its bytes are in.
    initial begin : compare_resp
        dbg_pkg::word_t got;
        dbg_pkg::word_t exp_w;
        int             nb;
        forever begin
            @(negedge i_clock);
            if (exp_nb.size() > 0 && rx_bytes.size() >= exp_nb[0]) begin
                nb    = exp_nb.pop_front();
                exp_w = exp_word.pop_front();
                got   = '0;
                repeat (nb) got = {got[23:0], rx_bytes.pop_front()};
                if (nb == 4) check_word(got, exp_w);
                else check_byte(got[7:0], exp_w[7:0]);
            end
        end
    end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge i_clock);
            cycles++;
        end
        $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    //////////////////////////////
    // Test sequence.
    //////////////////////////////
    initial begin : main_seq
        dbg_pkg::addr_t p_addr [3];
        int             base;
        dbg_pkg::addr_t d;
        dbg_pkg::addr_t d2;
        dbg_pkg::addr_t wa;
        void'($urandom(32'he0ee));
        for (int i = 0; i < DEPTH; i++) dirty_m[i] = 1'b0;
        i_arst_n <= 1'b0;
        i_rx     <= 1'b1;   // Line idle.
        repeat (5) @(posedge i_clock);
        i_arst_n <= 1'b1;
        repeat (4) @(posedge i_clock);

        base = int'($urandom % DEPTH);
        for (int i = 0; i < 3; i++) begin
            p_addr[i] = dbg_pkg::addr_t'((base + 5 * i) % DEPTH);
            run_test("prog write", dbg_pkg::OP_WR_PROG, p_addr[i], $urandom);
        end
        for (int i = 0; i < 3; i++) run_test("prog read", dbg_pkg::OP_RD_PROG, p_addr[i], '0);

        d  = dbg_pkg::addr_t'($urandom % DEPTH);
        d2 = dbg_pkg::addr_t'((int'(d) + 7) % DEPTH);
        run_test("data read clean", dbg_pkg::OP_RD_DATA, d, '0);
        run_test("dirty read clean", dbg_pkg::OP_RD_DIRTY, d, '0);
        run_test("data write", dbg_pkg::OP_WR_DATA, d, $urandom);
        run_test("data read written", dbg_pkg::OP_RD_DATA, d, '0);
        run_test("dirty read written", dbg_pkg::OP_RD_DIRTY, d, '0);

        // Soft reset wipes dirty bits only.
        run_test("data write second", dbg_pkg::OP_WR_DATA, d2, $urandom);
        run_test("soft reset", dbg_pkg::OP_SOFT_RESET, '0, '0);
        run_test("data read after reset", dbg_pkg::OP_RD_DATA, d, '0);
        run_test("dirty read after reset", dbg_pkg::OP_RD_DIRTY, d, '0);
        run_test("data read second after reset", dbg_pkg::OP_RD_DATA, d2, '0);
        run_test("dirty read second after reset", dbg_pkg::OP_RD_DIRTY, d2, '0);
        run_test("prog kept after reset", dbg_pkg::OP_RD_PROG, p_addr[0], '0);

        run_test("bad opcode 00", 8'h00, '0, '0);
        run_test("bad opcode 07", 8'h07, '0, '0);
        run_test("bad opcode c3", 8'hC3, '0, '0);
        run_test("read after bad opcode", dbg_pkg::OP_RD_PROG, p_addr[1], '0);

        // Second command goes out while the first response is queued.
        send_cmd(dbg_pkg::OP_RD_PROG, p_addr[1], '0);
        send_cmd(dbg_pkg::OP_RD_PROG, p_addr[2], '0);
        finish_test("back to back reads");

        wa = dbg_pkg::addr_t'((base + 3) % DEPTH);
        run_test("prog write wrapped", dbg_pkg::OP_WR_PROG,
                 dbg_pkg::addr_t'(int'(wa) + DEPTH), $urandom);
        run_test("prog read wrapped", dbg_pkg::OP_RD_PROG, wa, '0);

        if (rx_bytes.size() != 0) begin
            $display("%0d unexpected bytes left on o_tx", rx_bytes.size());
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) $display("Everything OK");
        else $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cmd_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder #(
    parameter int RESP_CREDITS = 2
) (
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic [7:0] i_byte,
    input  logic       i_valid,
    input  logic       i_credit_ret,
    cmd_if.src         cmd
);

    localparam int CRW = $clog2(RESP_CREDITS + 1);

    dbg_pkg::dec_state_e state;
    logic [CRW-1:0]      credits;
    logic [1:0]          data_cnt;
    logic                issue;
    logic                is_write;

    assign issue     = (state == dbg_pkg::ST_ISSUE) && (credits != '0);
    assign cmd.valid = issue;
    assign is_write  = (cmd.op == dbg_pkg::OP_WR_PROG) || (cmd.op == dbg_pkg::OP_WR_DATA);

    ///////////////////////////////
    // Byte collection FSM.
    ///////////////////////////////
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= dbg_pkg::ST_OP;
            data_cnt <= '0;
        end else begin
            case (state)
                dbg_pkg::ST_OP: begin
                    if (i_valid) begin
                        case (i_byte)
                            dbg_pkg::OP_WR_PROG, dbg_pkg::OP_RD_PROG, dbg_pkg::OP_WR_DATA,
                            dbg_pkg::OP_RD_DATA, dbg_pkg::OP_RD_DIRTY:
                                state <= dbg_pkg::ST_ADDR;
                            default: state <= dbg_pkg::ST_ISSUE;   // Soft reset or bad byte.
                        endcase
                    end
                end
                dbg_pkg::ST_ADDR: begin
                    data_cnt <= '0;
                    if (i_valid) state <= is_write ? dbg_pkg::ST_DATA : dbg_pkg::ST_ISSUE;
                end
                dbg_pkg::ST_DATA: begin
                    if (i_valid) begin
                        data_cnt <= data_cnt + 1'b1;
                        if (data_cnt == 2'd3) state <= dbg_pkg::ST_ISSUE;
                    end
                end
                default: if (issue) state <= dbg_pkg::ST_OP;   // Stalls without a credit.
            endcase
        end
    end

    // Command fields.
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            case (state)
                dbg_pkg::ST_OP: begin
                    if (i_byte >= 8'h01 && i_byte <= 8'h06) cmd.op <= dbg_pkg::op_e'(i_byte);
                    else cmd.op <= dbg_pkg::OP_BAD;
                end
                dbg_pkg::ST_ADDR: cmd.addr <= i_byte;
                dbg_pkg::ST_DATA: cmd.data <= {cmd.data[23:0], i_byte};   // MSB first.
                default: ;
            endcase
        end
    end

    // One credit per response slot in the sender.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) credits <= CRW'(RESP_CREDITS);
        else credits <= credits + CRW'(i_credit_ret) - CRW'(issue);
    end

    a_credit_max: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        credits <= CRW'(RESP_CREDITS));

    // Host sent more than RESP_CREDITS unanswered commands.
    a_no_rx_in_issue: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_valid |-> state != dbg_pkg::ST_ISSUE);

endmodule

`default_nettype wire

/* hw/dbg_if.sv */
`timescale 1ns/10ps
`default_nettype none

// One decoded command, strobed by valid.
interface cmd_if;
    logic              valid;
    dbg_pkg::op_e      op;
    dbg_pkg::addr_t    addr;
    dbg_pkg::word_t    data;

    modport src (output valid, output op, output addr, output data);
    modport dst (input valid, input op, input addr, input data);
endinterface

// One response, strobed by valid.
interface resp_if;
    logic              valid;
    dbg_pkg::word_t    word;
    logic [2:0]        nbytes;  // 1 or 4.

    modport src (output valid, output word, output nbytes);
    modport dst (input valid, input word, input nbytes);
endinterface

`default_nettype wire

/* hw/dbg_pkg.sv */
`default_nettype none

package dbg_pkg;

    ///////////////////////////////
    // Data types.
    ///////////////////////////////
    typedef logic [31:0] word_t;   // One memory word.
    typedef logic [7:0]  addr_t;   // One address byte.

    // Command opcodes as they arrive on the serial line.
    typedef enum logic [7:0] {
        OP_WR_PROG    = 8'h01,
        OP_RD_PROG    = 8'h02,
        OP_WR_DATA    = 8'h03,
        OP_RD_DATA    = 8'h04,
        OP_RD_DIRTY   = 8'h05,
        OP_SOFT_RESET = 8'h06,
        OP_BAD        = 8'hFF  // Stands in for any unknown byte.
    } op_e;

    // Decoder FSM.
    typedef enum logic [1:0] {
        ST_OP,
        ST_ADDR,
        ST_DATA,
        ST_ISSUE
    } dec_state_e;

    ///////////////////////////////
    // Response bytes.
    ///////////////////////////////
    localparam logic [7:0] RESP_ACK = 8'h5A;  // Write or soft reset done.
    localparam logic [7:0] RESP_ERR = 8'hEE;  // Unknown opcode.

endpackage

`default_nettype wire

/* hw/dbg_uart_top.sv */
`timescale 1ns/10ps
`default_nettype none

module dbg_uart_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int PROG_DEPTH   = 256,
    parameter int DATA_DEPTH   = 256,
    parameter int RESP_CREDITS = 2
) (
    input  logic i_clock,
    input  logic i_arst_n,
    input  logic i_rx,
    output logic o_tx
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_done;
    logic       credit_ret;

    cmd_if  cmd_bus ();
    resp_if resp_bus ();

    ///////////////////////////////
    // Command path.
    ///////////////////////////////
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .i_clock (i_clock),
        .i_arst_n(i_arst_n),
        .i_rx    (i_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    cmd_decoder #(.RESP_CREDITS(RESP_CREDITS)) u_cmd_decoder (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_byte      (rx_byte),
        .i_valid     (rx_valid),
        .i_credit_ret(credit_ret),
        .cmd         (cmd_bus.src)
    );

    mem_exec #(.PROG_DEPTH(PROG_DEPTH), .DATA_DEPTH(DATA_DEPTH)) u_mem_exec (
        .i_clock (i_clock),
        .i_arst_n(i_arst_n),
        .cmd     (cmd_bus.dst),
        .resp    (resp_bus.src)
    );

    ///////////////////////////////
    // Response path.
    ///////////////////////////////
    resp_sender #(.RESP_CREDITS(RESP_CREDITS)) u_resp_sender (
        .i_clock     (i_clock),
        .i_arst_n    (i_arst_n),
        .i_tx_done   (tx_done),
        .resp        (resp_bus.dst),
        .o_tx_byte   (tx_byte),
        .o_tx_start  (tx_start),
        .o_credit_ret(credit_ret)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .i_clock (i_clock),
        .i_arst_n(i_arst_n),
        .i_start (tx_start),
        .i_byte  (tx_byte),
        .o_tx    (o_tx),
        .o_done  (tx_done)
    );

endmodule

`default_nettype wire

/* hw/mem_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_exec #(
    parameter int PROG_DEPTH = 256,
    parameter int DATA_DEPTH = 256
) (
    input  logic i_clock,
    input  logic i_arst_n,
    cmd_if.dst   cmd,
    resp_if.src  resp
);

    localparam int PAW = (PROG_DEPTH > 1) ? $clog2(PROG_DEPTH) : 1;
    localparam int DAW = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;

    dbg_pkg::word_t        prog_mem [PROG_DEPTH];
    dbg_pkg::word_t        data_mem [DATA_DEPTH];
    logic [DATA_DEPTH-1:0] dirty;
    logic [PAW-1:0]        p_idx;
    logic [DAW-1:0]        d_idx;

    // Addresses past the depth wrap around.
    assign p_idx = PAW'({1'b0, cmd.addr} % 9'(PROG_DEPTH));
    assign d_idx = DAW'({1'b0, cmd.addr} % 9'(DATA_DEPTH));

    ///////////////////////////////
    // Memory arrays.
    ///////////////////////////////
    always_ff @(posedge i_clock) begin
        if (cmd.valid && cmd.op == dbg_pkg::OP_WR_PROG) prog_mem[p_idx] <= cmd.data;
        if (cmd.valid && cmd.op == dbg_pkg::OP_WR_DATA) data_mem[d_idx] <= cmd.data;
    end

    // Dirty bits, one per data word.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dirty <= '0;
        end else if (cmd.valid) begin
            if (cmd.op == dbg_pkg::OP_SOFT_RESET) dirty <= '0;
            else if (cmd.op == dbg_pkg::OP_WR_DATA) dirty[d_idx] <= 1'b1;
        end
    end

    ///////////////////////////////
    // Response build.
    ///////////////////////////////
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) resp.valid <= 1'b0;
        else resp.valid <= cmd.valid;
    end

    always_ff @(posedge i_clock) begin
        if (cmd.valid) begin
            case (cmd.op)
                dbg_pkg::OP_RD_PROG: begin
                    resp.word   <= prog_mem[p_idx];
                    resp.nbytes <= 3'd4;
                end
                dbg_pkg::OP_RD_DATA: begin
                    resp.word   <= dirty[d_idx] ? data_mem[d_idx] : '0;   // Clean reads as zero.
                    resp.nbytes <= 3'd4;
                end
                dbg_pkg::OP_RD_DIRTY: begin
                    resp.word   <= {31'd0, dirty[d_idx]};
                    resp.nbytes <= 3'd1;
                end
                dbg_pkg::OP_BAD: begin
                    resp.word   <= {24'd0, dbg_pkg::RESP_ERR};
                    resp.nbytes <= 3'd1;
                end
                default: begin   // Writes and soft reset.
                    resp.word   <= {24'd0, dbg_pkg::RESP_ACK};
                    resp.nbytes <= 3'd1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/resp_sender.sv */
`timescale 1ns/10ps
`default_nettype none

module resp_sender #(
    parameter int RESP_CREDITS = 2
) (
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_tx_done,
    resp_if.dst        resp,
    output logic [7:0] o_tx_byte,
    output logic       o_tx_start,
    output logic       o_credit_ret
);

    localparam int PW = (RESP_CREDITS > 1) ? $clog2(RESP_CREDITS) : 1;
    localparam int CW = $clog2(RESP_CREDITS + 1);

    dbg_pkg::word_t fifo_word [RESP_CREDITS];
    logic [2:0]     fifo_nb   [RESP_CREDITS];
    logic [PW-1:0]  wr_ptr, rd_ptr;
    logic [CW-1:0]  count;
    logic           busy;        // Head response is being sent.
    logic           next_start;  // Start the following byte.
    logic [1:0]     rem;         // Bytes left after the current one.
    logic [1:0]     sel;
    logic           pop;

    ///////////////////////////////
    // Byte selection.
    ///////////////////////////////
    assign sel          = busy ? rem : 2'(fifo_nb[rd_ptr] - 3'd1);
    assign o_tx_byte    = fifo_word[rd_ptr][8*sel +: 8];   // Top byte first.
    assign o_tx_start   = (!busy && count != '0) || next_start;
    assign pop          = busy && i_tx_done && (rem == 2'd0);
    assign o_credit_ret = pop;

    always_ff @(posedge i_clock) begin
        if (resp.valid) begin
            fifo_word[wr_ptr] <= resp.word;
            fifo_nb[wr_ptr]   <= resp.nbytes;
        end
    end

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            busy       <= 1'b0;
            next_start <= 1'b0;
            rem        <= '0;
        end else begin
            next_start <= 1'b0;
            count      <= count + CW'(resp.valid) - CW'(pop);
            if (resp.valid) wr_ptr <= (wr_ptr == PW'(RESP_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (!busy && count != '0) begin
                busy <= 1'b1;
                rem  <= sel;
            end else if (busy && i_tx_done) begin
                if (rem == 2'd0) begin
                    busy   <= 1'b0;
                    rd_ptr <= (rd_ptr == PW'(RESP_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
                end else begin
                    rem        <= rem - 1'b1;
                    next_start <= 1'b1;
                end
            end
        end
    end

    // Credits keep the FIFO from ever filling past its depth.
    a_no_overflow: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        resp.valid |-> count < CW'(RESP_CREDITS));

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_valid
);

    localparam int CW   = $clog2(CLKS_PER_BIT);
    localparam int HALF = CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [1:0]    sync;   // Two-flop synchronizer.
    logic [7:0]    shift;
    logic          bit_end;

    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    assign o_byte  = shift;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            sync    <= 2'b11;   // Line idles high.
            o_valid <= 1'b0;
        end else begin
            sync    <= {sync[0], i_rx};
            o_valid <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!sync[1]) state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == CW'(HALF - 1)) begin   // Middle of start bit.
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= sync[1] ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) begin
                        o_valid <= sync[1];   // Framing error drops the byte.
                        state   <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && bit_end) shift <= {sync[1], shift[7:1]};
    end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       i_clock,
    input  logic       i_arst_n,
    input  logic       i_start,
    input  logic [7:0] i_byte,
    output logic       o_tx,
    output logic       o_done
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e     state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift;
    logic          bit_end;

    assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            o_tx    <= 1'b1;
            o_done  <= 1'b0;
        end else begin
            o_done  <= 1'b0;
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (i_start) begin
                        state <= TX_START;
                        o_tx  <= 1'b0;   // Start bit.
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        o_tx    <= shift[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                            o_tx  <= 1'b1;
                        end else begin
                            o_tx  <= shift[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state  <= TX_IDLE;
                        o_done <= 1'b1;   // Stop bit finished.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == TX_IDLE && i_start) shift <= i_byte;
        else if (state == TX_DATA && bit_end) shift <= shift >> 1;
    end

    // The sender must wait for o_done before the next byte.
    a_start_idle: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_start |-> state == TX_IDLE);

endmodule

`default_nettype wire
